//--- hw/pipe_sel.sv
package pipe_sel;

    // where each EX operand comes from
    typedef enum logic [1:0] {
        // value read in ID, no hazard
        id_ex  = 2'b00,
        // alu result one stage ahead
        ex_mem = 2'b01,
        // writeback value two stages ahead
        mem_wb = 2'b10
    } forward_sel_t;

    // alu operand b source
    typedef enum logic {
        rs2_data = 1'b0,
        imm_data = 1'b1
    } alumux2_sel_t;

endpackage

//--- hw/rv32i_types.sv
package rv32i_types;

    // data and address word
    typedef logic [31:0] rv32i_word;

    // major opcodes, supported subset only
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111
    } opcode_t;

    // low three bits mirror funct3
    // bit 3 selects the alternate form (sub, sra)
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        // lui just passes the u-immediate
        alu_pass_b = 4'b1111
    } alu_ops_t;

    // travels whole from ID down to WB
    // all zero means no side effects at all
    typedef struct packed {
        alu_ops_t               aluop;
        pipe_sel::alumux2_sel_t alumux2_sel;
        logic                   mem_read;
        logic                   mem_write;
        logic                   load_regfile;
        // 0 picks alu result, 1 picks load data
        logic                   regfilemux_sel;
    } rv32i_control_word;

    // addi x0, x0, 0
    localparam rv32i_word nop_instr = 32'h0000_0013;

endpackage

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   we_i,
    input  logic [4:0]             rd_i,
    input  rv32i_types::rv32i_word wdata_i,
    input  logic [4:0]             rs1_i,
    input  logic [4:0]             rs2_i,
    output rv32i_types::rv32i_word rs1_data_o,
    output rv32i_types::rv32i_word rs2_data_o
);

    rv32i_types::rv32i_word regs [0:31];
    logic                   wr_en;

    // x0 never gets written, so it stays zero after reset
    assign wr_en = we_i & (rd_i != 5'd0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // bypass the write of this cycle straight to the readers
    // covers the wb -> id distance of three
    assign rs1_data_o = (wr_en && (rd_i == rs1_i)) ? wdata_i : regs[rs1_i];
    assign rs2_data_o = (wr_en && (rd_i == rs2_i)) ? wdata_i : regs[rs2_i];

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  rv32i_types::rv32i_word         instr_i,
    input  logic                           bubble_i,
    input  logic                           wb_we_i,
    input  logic [4:0]                     wb_rd_i,
    input  rv32i_types::rv32i_word         wb_data_i,
    output rv32i_types::rv32i_control_word ctrl_o,
    output rv32i_types::rv32i_word         rs1_data_o,
    output rv32i_types::rv32i_word         rs2_data_o,
    output rv32i_types::rv32i_word         imm_o,
    output logic [4:0]                     rs1_o,
    output logic [4:0]                     rs2_o,
    output logic [4:0]                     rd_o
);

    rv32i_types::opcode_t           opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic                           alt_op;
    rv32i_types::rv32i_control_word ctrl;

    assign opcode = rv32i_types::opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // sub exists only in register form, sra/srai in both
    assign alt_op = funct7[5]
                  & ((funct3 == 3'b101)
                  | ((opcode == rv32i_types::op_reg) & (funct3 == 3'b000)));

    always_comb begin
        ctrl  = '0;
        imm_o = '0;
        rs1_o = '0;
        rs2_o = '0;
        rd_o  = '0;
        // indices stay zero when the format has no such field
        // keeps hazard and forwarding from matching junk bits
        case (opcode)
            rv32i_types::op_reg: begin
                ctrl.aluop        = rv32i_types::alu_ops_t'({alt_op, funct3});
                ctrl.load_regfile = 1'b1;
                rs1_o             = instr_i[19:15];
                rs2_o             = instr_i[24:20];
                rd_o              = instr_i[11:7];
            end
            rv32i_types::op_imm: begin
                ctrl.aluop        = rv32i_types::alu_ops_t'({alt_op, funct3});
                ctrl.alumux2_sel  = pipe_sel::imm_data;
                ctrl.load_regfile = 1'b1;
                imm_o             = {{20{instr_i[31]}}, instr_i[31:20]};
                rs1_o             = instr_i[19:15];
                rd_o              = instr_i[11:7];
            end
            rv32i_types::op_lui: begin
                ctrl.aluop        = rv32i_types::alu_pass_b;
                ctrl.alumux2_sel  = pipe_sel::imm_data;
                ctrl.load_regfile = 1'b1;
                imm_o             = {instr_i[31:12], 12'h000};
                rd_o              = instr_i[11:7];
            end
            rv32i_types::op_load: begin
                // address is rs1 + i-imm
                ctrl.aluop          = rv32i_types::alu_add;
                ctrl.alumux2_sel    = pipe_sel::imm_data;
                ctrl.mem_read       = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = 1'b1;
                imm_o               = {{20{instr_i[31]}}, instr_i[31:20]};
                rs1_o               = instr_i[19:15];
                rd_o                = instr_i[11:7];
            end
            rv32i_types::op_store: begin
                // address is rs1 + s-imm, data is rs2
                ctrl.aluop       = rv32i_types::alu_add;
                ctrl.alumux2_sel = pipe_sel::imm_data;
                ctrl.mem_write   = 1'b1;
                imm_o            = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                rs1_o            = instr_i[19:15];
                rs2_o            = instr_i[24:20];
            end
            // anything unsupported decodes as a nop
            default: ;
        endcase
    end

    // bubble kills every side effect of the slot
    assign ctrl_o = bubble_i ? '0 : ctrl;

    regfile i_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .wdata_i    (wb_data_i),
        .rs1_i      (instr_i[19:15]),
        .rs2_i      (instr_i[24:20]),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

//--- hw/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
    input  logic [4:0]             ex_rs1_i,
    input  logic [4:0]             ex_rs2_i,
    input  logic [4:0]             mem_rd_i,
    input  logic                   mem_load_regfile_i,
    input  logic [4:0]             wb_rd_i,
    input  logic                   wb_load_regfile_i,
    output pipe_sel::forward_sel_t forward_a_o,
    output pipe_sel::forward_sel_t forward_b_o
);

    // one operand, same rule for a and b
    function automatic pipe_sel::forward_sel_t pick_source(
        input logic [4:0] rs,
        input logic [4:0] mem_rd,
        input logic       mem_we,
        input logic [4:0] wb_rd,
        input logic       wb_we
    );
        pipe_sel::forward_sel_t sel;
        sel = pipe_sel::id_ex;
        if (wb_we && (wb_rd != 5'd0) && (wb_rd == rs)) begin
            sel = pipe_sel::mem_wb;
        end
        // younger result wins
        // loads never sit here with a consumer in EX, the stall spaced them
        if (mem_we && (mem_rd != 5'd0) && (mem_rd == rs)) begin
            sel = pipe_sel::ex_mem;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a_o = pick_source(ex_rs1_i, mem_rd_i, mem_load_regfile_i,
                                  wb_rd_i, wb_load_regfile_i);
        forward_b_o = pick_source(ex_rs2_i, mem_rd_i, mem_load_regfile_i,
                                  wb_rd_i, wb_load_regfile_i);
    end

endmodule

//--- hw/hazard_detector.sv
`timescale 1ns/1ps

module hazard_detector (
    input  logic [4:0]                     id_rs1_i,
    input  logic [4:0]                     id_rs2_i,
    input  rv32i_types::rv32i_control_word ex_ctrl_i,
    input  logic [4:0]                     ex_rd_i,
    output logic                           stall_o
);

    logic ex_is_load;
    logic rs1_hit;
    logic rs2_hit;

    // load in EX, data only shows up in MEM
    assign ex_is_load = ex_ctrl_i.mem_read & (ex_rd_i != 5'd0);

    // unused ID indices come in as zero and never hit
    assign rs1_hit = (id_rs1_i == ex_rd_i);
    assign rs2_hit = (id_rs2_i == ex_rd_i);

    // one cycle is enough, MEM/WB forwarding covers the rest
    assign stall_o = ex_is_load & (rs1_hit | rs2_hit);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  rv32i_types::rv32i_control_word ctrl_i,
    input  rv32i_types::rv32i_word         rs1_data_i,
    input  rv32i_types::rv32i_word         rs2_data_i,
    input  rv32i_types::rv32i_word         imm_i,
    input  pipe_sel::forward_sel_t         forward_a_i,
    input  pipe_sel::forward_sel_t         forward_b_i,
    input  rv32i_types::rv32i_word         mem_alu_out_i,
    input  rv32i_types::rv32i_word         wb_data_i,
    output rv32i_types::rv32i_word         alu_out_o,
    output rv32i_types::rv32i_word         store_data_o
);

    rv32i_types::rv32i_word op_a;
    rv32i_types::rv32i_word rs2_fwd;
    rv32i_types::rv32i_word op_b;

    // forwarding mux, shared by both operands
    function automatic rv32i_types::rv32i_word fwd_mux(
        input pipe_sel::forward_sel_t sel,
        input rv32i_types::rv32i_word id_ex_val,
        input rv32i_types::rv32i_word ex_mem_val,
        input rv32i_types::rv32i_word mem_wb_val
    );
        case (sel)
            pipe_sel::ex_mem: return ex_mem_val;
            pipe_sel::mem_wb: return mem_wb_val;
            default:          return id_ex_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(forward_a_i, rs1_data_i, mem_alu_out_i, wb_data_i);
    assign rs2_fwd = fwd_mux(forward_b_i, rs2_data_i, mem_alu_out_i, wb_data_i);

    // immediate for i/s/u forms
    assign op_b = (ctrl_i.alumux2_sel == pipe_sel::imm_data) ? imm_i : rs2_fwd;

    // stores take the forwarded rs2, never the immediate
    assign store_data_o = rs2_fwd;

    always_comb begin
        case (ctrl_i.aluop)
            rv32i_types::alu_add:    alu_out_o = op_a + op_b;
            rv32i_types::alu_sub:    alu_out_o = op_a - op_b;
            // shift amount is the low five bits only
            rv32i_types::alu_sll:    alu_out_o = op_a << op_b[4:0];
            rv32i_types::alu_slt:    alu_out_o = {31'd0, $signed(op_a) < $signed(op_b)};
            rv32i_types::alu_sltu:   alu_out_o = {31'd0, op_a < op_b};
            rv32i_types::alu_xor:    alu_out_o = op_a ^ op_b;
            rv32i_types::alu_srl:    alu_out_o = op_a >> op_b[4:0];
            rv32i_types::alu_sra:    alu_out_o = $signed(op_a) >>> op_b[4:0];
            rv32i_types::alu_or:     alu_out_o = op_a | op_b;
            rv32i_types::alu_and:    alu_out_o = op_a & op_b;
            rv32i_types::alu_pass_b: alu_out_o = op_b;
            default:                 alu_out_o = op_a + op_b;
        endcase
    end

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rv32i_types::rv32i_word instr_mem_rdata_i,
    input  rv32i_types::rv32i_word data_mem_rdata_i,
    output rv32i_types::rv32i_word instr_mem_address_o,
    output rv32i_types::rv32i_word data_mem_address_o,
    output rv32i_types::rv32i_word data_mem_wdata_o,
    output logic                   data_read_o,
    output logic                   data_write_o
);

    // fetch
    rv32i_types::rv32i_word         pc;
    // IF/ID
    rv32i_types::rv32i_word         if_id_instr;
    // decode outputs
    rv32i_types::rv32i_control_word id_ctrl;
    rv32i_types::rv32i_word         id_rs1_data;
    rv32i_types::rv32i_word         id_rs2_data;
    rv32i_types::rv32i_word         id_imm;
    logic [4:0]                     id_rs1;
    logic [4:0]                     id_rs2;
    logic [4:0]                     id_rd;
    // ID/EX
    rv32i_types::rv32i_control_word id_ex_ctrl;
    rv32i_types::rv32i_word         id_ex_rs1_data;
    rv32i_types::rv32i_word         id_ex_rs2_data;
    rv32i_types::rv32i_word         id_ex_imm;
    logic [4:0]                     id_ex_rs1;
    logic [4:0]                     id_ex_rs2;
    logic [4:0]                     id_ex_rd;
    // execute outputs
    rv32i_types::rv32i_word         ex_alu_out;
    rv32i_types::rv32i_word         ex_store_data;
    // EX/MEM
    rv32i_types::rv32i_control_word ex_mem_ctrl;
    rv32i_types::rv32i_word         ex_mem_alu_out;
    rv32i_types::rv32i_word         ex_mem_store_data;
    logic [4:0]                     ex_mem_rd;
    // MEM/WB
    rv32i_types::rv32i_control_word mem_wb_ctrl;
    rv32i_types::rv32i_word         mem_wb_alu_out;
    rv32i_types::rv32i_word         mem_wb_rdata;
    logic [4:0]                     mem_wb_rd;
    rv32i_types::rv32i_word         wb_data;
    // hazard and forwarding
    logic                           stall;
    pipe_sel::forward_sel_t         forward_a;
    pipe_sel::forward_sel_t         forward_b;

    // pc only steps by 4, holds during a load-use stall
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign instr_mem_address_o = pc;

    // IF/ID freezes with the pc
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_instr <= rv32i_types::nop_instr;
        end else if (!stall) begin
            if_id_instr <= instr_mem_rdata_i;
        end
    end

    decode_stage i_decode_stage (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .instr_i    (if_id_instr),
        .bubble_i   (stall),
        .wb_we_i    (mem_wb_ctrl.load_regfile),
        .wb_rd_i    (mem_wb_rd),
        .wb_data_i  (wb_data),
        .ctrl_o     (id_ctrl),
        .rs1_data_o (id_rs1_data),
        .rs2_data_o (id_rs2_data),
        .imm_o      (id_imm),
        .rs1_o      (id_rs1),
        .rs2_o      (id_rs2),
        .rd_o       (id_rd)
    );

    hazard_detector i_hazard_detector (
        .id_rs1_i  (id_rs1),
        .id_rs2_i  (id_rs2),
        .ex_ctrl_i (id_ex_ctrl),
        .ex_rd_i   (id_ex_rd),
        .stall_o   (stall)
    );

    // ID/EX never stalls, a stall loads the bubble instead
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_ctrl     <= '0;
            id_ex_rs1_data <= '0;
            id_ex_rs2_data <= '0;
            id_ex_imm      <= '0;
            id_ex_rs1      <= '0;
            id_ex_rs2      <= '0;
            id_ex_rd       <= '0;
        end else begin
            id_ex_ctrl     <= id_ctrl;
            id_ex_rs1_data <= id_rs1_data;
            id_ex_rs2_data <= id_rs2_data;
            id_ex_imm      <= id_imm;
            id_ex_rs1      <= id_rs1;
            id_ex_rs2      <= id_rs2;
            id_ex_rd       <= id_rd;
        end
    end

    forwarding_unit i_forwarding_unit (
        .ex_rs1_i           (id_ex_rs1),
        .ex_rs2_i           (id_ex_rs2),
        .mem_rd_i           (ex_mem_rd),
        .mem_load_regfile_i (ex_mem_ctrl.load_regfile),
        .wb_rd_i            (mem_wb_rd),
        .wb_load_regfile_i  (mem_wb_ctrl.load_regfile),
        .forward_a_o        (forward_a),
        .forward_b_o        (forward_b)
    );

    execute_stage i_execute_stage (
        .ctrl_i        (id_ex_ctrl),
        .rs1_data_i    (id_ex_rs1_data),
        .rs2_data_i    (id_ex_rs2_data),
        .imm_i         (id_ex_imm),
        .forward_a_i   (forward_a),
        .forward_b_i   (forward_b),
        .mem_alu_out_i (ex_mem_alu_out),
        .wb_data_i     (wb_data),
        .alu_out_o     (ex_alu_out),
        .store_data_o  (ex_store_data)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_ctrl       <= '0;
            ex_mem_alu_out    <= '0;
            ex_mem_store_data <= '0;
            ex_mem_rd         <= '0;
        end else begin
            ex_mem_ctrl       <= id_ex_ctrl;
            ex_mem_alu_out    <= ex_alu_out;
            ex_mem_store_data <= ex_store_data;
            ex_mem_rd         <= id_ex_rd;
        end
    end

    // magic data memory, answers in this same cycle
    assign data_mem_address_o = ex_mem_alu_out;
    assign data_mem_wdata_o   = ex_mem_store_data;
    assign data_read_o        = ex_mem_ctrl.mem_read;
    assign data_write_o       = ex_mem_ctrl.mem_write;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_ctrl    <= '0;
            mem_wb_alu_out <= '0;
            mem_wb_rdata   <= '0;
            mem_wb_rd      <= '0;
        end else begin
            mem_wb_ctrl    <= ex_mem_ctrl;
            mem_wb_alu_out <= ex_mem_alu_out;
            mem_wb_rdata   <= data_mem_rdata_i;
            mem_wb_rd      <= ex_mem_rd;
        end
    end

    // writeback mux, also the mem_wb forwarding source
    assign wb_data = mem_wb_ctrl.regfilemux_sel ? mem_wb_rdata : mem_wb_alu_out;

endmodule

//--- tb/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;

    logic                   clk_i;
    logic                   arst_n_i;
    rv32i_types::rv32i_word instr_mem_rdata_i;
    rv32i_types::rv32i_word data_mem_rdata_i;
    rv32i_types::rv32i_word instr_mem_address_o;
    rv32i_types::rv32i_word data_mem_address_o;
    rv32i_types::rv32i_word data_mem_wdata_o;
    logic                   data_read_o;
    logic                   data_write_o;

    // program image and 1 KB data memory
    rv32i_types::rv32i_word imem [0:511];
    rv32i_types::rv32i_word dmem [0:255];
    int                     prog_len;
    rv32i_types::rv32i_word prog [$];
    // expected stores from the ISA model
    rv32i_types::rv32i_word exp_addr [$];
    rv32i_types::rv32i_word exp_data [$];
    // expected load addresses in program order
    rv32i_types::rv32i_word exp_load [$];
    int                     exp_cnt;
    int                     got_cnt;
    int                     load_cnt;
    logic [31:0]            lfsr_state = 32'h1a8a0314;

    initial begin
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        prog_len = 0;
        exp_cnt  = 0;
        got_cnt  = 0;
        load_cnt = 0;
        // data memory holds defined words from time zero
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
    end

    // 40 ns period
    always #20 clk_i = ~clk_i;

    datapath i_datapath (
        .clk_i               (clk_i),
        .arst_n_i            (arst_n_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .data_mem_rdata_i    (data_mem_rdata_i),
        .instr_mem_address_o (instr_mem_address_o),
        .data_mem_address_o  (data_mem_address_o),
        .data_mem_wdata_o    (data_mem_wdata_o),
        .data_read_o         (data_read_o),
        .data_write_o        (data_write_o)
    );

    // past the program the fetch sees nops
    assign instr_mem_rdata_i = (int'(instr_mem_address_o[31:2]) < prog_len)
                             ? imem[instr_mem_address_o[10:2]] : rv32i_types::nop_instr;
    assign data_mem_rdata_i  = dmem[data_mem_address_o[9:2]];

    // write strobe taken at the edge that closes MEM
    always @(posedge clk_i) begin
        if (data_write_o) begin
            dmem[data_mem_address_o[9:2]] <= data_mem_wdata_o;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input rv32i_types::rv32i_word got,
                              input rv32i_types::rv32i_word exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                    name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                    name, got, exp));
        end
    endtask

    // stores and loads sampled on the edge that ends the MEM cycle
    always @(posedge clk_i) begin
        if (arst_n_i && data_write_o) begin
            if (got_cnt >= exp_cnt) begin
                stop_on_error("the DUT issued more stores than the reference model");
            end else begin
                check_word("data_mem_address_o", data_mem_address_o, exp_addr[got_cnt]);
                check_word("data_mem_wdata_o", data_mem_wdata_o, exp_data[got_cnt]);
            end
            got_cnt <= got_cnt + 1;
        end
        // every load must show up with its own address
        if (arst_n_i && data_read_o) begin
            if (load_cnt >= exp_load.size()) begin
                stop_on_error("the DUT issued more loads than the reference model");
            end else begin
                check_word("data_mem_address_o", data_mem_address_o, exp_load[load_cnt]);
            end
            load_cnt <= load_cnt + 1;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // initial data depends on every address bit
    function automatic rv32i_types::rv32i_word fill_word(input int idx);
        logic [31:0] a;
        a = idx * 4;
        return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic rv32i_types::rv32i_word enc_r(input logic [6:0] f7, input int rs2,
                                                      input int rs1, input logic [2:0] f3,
                                                      input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic rv32i_types::rv32i_word enc_i(input logic [11:0] imm, input int rs1,
                                                      input logic [2:0] f3, input int rd,
                                                      input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic rv32i_types::rv32i_word enc_s(input logic [11:0] imm, input int rs2,
                                                      input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_types::rv32i_word enc_u(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    // rv32i alu semantics by funct3
    // alt comes from instr bit 30
    function automatic rv32i_types::rv32i_word alu_ref(input logic [2:0] f3, input logic alt,
                                                        input logic [31:0] a,
                                                        input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // sequential ISA model that fills the expected store and load lists
    function automatic int ref_run();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:255];
        logic [31:0] ins;
        logic [31:0] res;
        logic [31:0] addr;
        logic        wr;
        int          rd;
        int          rs1;
        int          rs2;
        exp_addr.delete();
        exp_data.delete();
        exp_load.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < prog.size(); i++) begin
            ins = prog[i];
            rd  = ins[11:7];
            rs1 = ins[19:15];
            rs2 = ins[24:20];
            wr  = 1'b1;
            res = '0;
            case (ins[6:0])
                7'b0110011: begin
                    res = alu_ref(ins[14:12], ins[30] & (ins[14:12] inside {3'd0, 3'd5}),
                                  regs[rs1], regs[rs2]);
                end
                7'b0010011: begin
                    res = alu_ref(ins[14:12], ins[30] & (ins[14:12] == 3'd5),
                                  regs[rs1], {{20{ins[31]}}, ins[31:20]});
                end
                7'b0110111: res = {ins[31:12], 12'h000};
                7'b0000011: begin
                    addr = regs[rs1] + {{20{ins[31]}}, ins[31:20]};
                    res  = mem[addr[9:2]];
                    exp_load.push_back(addr);
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = regs[rs1] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[9:2]] = regs[rs2];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[rs2]);
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != 0) begin
                regs[rd] = res;
            end
        end
        return exp_addr.size();
    endfunction

    // every register including x0 goes to 0x200 + 4*r
    task automatic emit_dump();
        for (int r = 0; r < 32; r++) begin
            prog.push_back(enc_s(12'(12'h200 + 4 * r), r, 0));
        end
    endtask

    task automatic run_program(input string name);
        int limit;
        int cycles;
        prog_len = prog.size();
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = prog[i];
        end
        exp_cnt  = ref_run();
        got_cnt  = 0;
        load_cnt = 0;
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
        end
        // reset held for 8 cycles
        for (int c = 0; c < 8; c++) begin
            @(negedge clk_i);
            check_word("instr_mem_address_o", instr_mem_address_o, '0);
            check_level("data_read_o", data_read_o, 1'b0);
            check_level("data_write_o", data_write_o, 1'b0);
            @(posedge clk_i);
        end
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        // first cycle out of reset
        check_word("instr_mem_address_o", instr_mem_address_o, '0);
        check_level("data_read_o", data_read_o, 1'b0);
        check_level("data_write_o", data_write_o, 1'b0);
        limit  = 2 * prog_len + 40;
        cycles = 0;
        while (got_cnt < exp_cnt) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > limit) begin
                stop_on_error($sformatf("program %s timed out after %0d cycles, %0d of %0d stores",
                                        name, cycles, got_cnt, exp_cnt));
            end
        end
        // drain the pipe so that any extra store trips the checker
        repeat (8) @(negedge clk_i);
        if (load_cnt != exp_load.size()) begin
            stop_on_error($sformatf("program %s issued %0d loads where %0d were expected",
                                    name, load_cnt, exp_load.size()));
        end
        $display("program %s done, %0d stores", name, got_cnt);
    endtask

    task automatic build_alu_program();
        prog.delete();
        prog.push_back(enc_u(20'h80001, 1));
        prog.push_back(enc_i(12'h123, 1, 3'd0, 1, 7'b0010011));
        prog.push_back(enc_i(12'hff9, 0, 3'd0, 2, 7'b0010011));
        prog.push_back(enc_r(7'h00, 2, 1, 3'd0, 3));
        prog.push_back(enc_r(7'h20, 1, 3, 3'd0, 4));
        prog.push_back(enc_r(7'h00, 2, 4, 3'd1, 5));
        prog.push_back(enc_r(7'h00, 1, 2, 3'd2, 6));
        prog.push_back(enc_r(7'h00, 1, 2, 3'd3, 7));
        prog.push_back(enc_r(7'h00, 3, 6, 3'd4, 8));
        prog.push_back(enc_r(7'h00, 2, 1, 3'd5, 9));
        prog.push_back(enc_r(7'h20, 2, 1, 3'd5, 10));
        prog.push_back(enc_r(7'h00, 10, 9, 3'd6, 11));
        prog.push_back(enc_r(7'h00, 3, 11, 3'd7, 12));
        prog.push_back(enc_i(12'hfff, 12, 3'd2, 13, 7'b0010011));
        prog.push_back(enc_i(12'h005, 12, 3'd3, 14, 7'b0010011));
        prog.push_back(enc_i(12'h555, 14, 3'd4, 15, 7'b0010011));
        prog.push_back(enc_i(12'h0f0, 15, 3'd6, 16, 7'b0010011));
        prog.push_back(enc_i(12'h03c, 16, 3'd7, 17, 7'b0010011));
        prog.push_back(enc_i(12'h004, 1, 3'd1, 18, 7'b0010011));
        prog.push_back(enc_i(12'h007, 1, 3'd5, 19, 7'b0010011));
        prog.push_back(enc_i(12'h409, 1, 3'd5, 20, 7'b0010011));
        // x0 writes must vanish
        prog.push_back(enc_i(12'h001, 1, 3'd0, 0, 7'b0010011));
        prog.push_back(enc_r(7'h00, 4, 3, 3'd0, 0));
        prog.push_back(enc_u(20'hfffff, 21));
        prog.push_back(enc_r(7'h00, 20, 21, 3'd0, 22));
        // distance three followed by distance two
        prog.push_back(enc_i(12'h001, 1, 3'd0, 23, 7'b0010011));
        prog.push_back(rv32i_types::nop_instr);
        prog.push_back(rv32i_types::nop_instr);
        prog.push_back(enc_r(7'h00, 23, 23, 3'd0, 24));
        prog.push_back(enc_i(12'h003, 2, 3'd0, 25, 7'b0010011));
        prog.push_back(rv32i_types::nop_instr);
        prog.push_back(enc_r(7'h20, 1, 25, 3'd0, 26));
        emit_dump();
    endtask

    task automatic build_load_program();
        prog.delete();
        prog.push_back(enc_i(12'h010, 0, 3'd2, 7, 7'b0000011));
        prog.push_back(enc_r(7'h00, 7, 7, 3'd0, 8));
        prog.push_back(enc_s(12'h020, 8, 0));
        prog.push_back(enc_i(12'h020, 0, 3'd2, 9, 7'b0000011));
        // load straight into store data
        prog.push_back(enc_s(12'h024, 9, 0));
        prog.push_back(enc_i(12'h028, 0, 3'd2, 10, 7'b0000011));
        prog.push_back(enc_i(12'h001, 10, 3'd0, 11, 7'b0010011));
        prog.push_back(enc_r(7'h00, 11, 10, 3'd4, 12));
        emit_dump();
    endtask

    task automatic build_random_program(input int len);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        prog.delete();
        for (int i = 0; i < len; i++) begin
            kind = 3'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            alt  = 1'(rand_bits(1));
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    prog.push_back(enc_r((alt && f3 inside {3'd0, 3'd5}) ? 7'h20 : 7'h00,
                                         rand_bits(5), rand_bits(5), f3, rand_bits(5)));
                end
                3'd3, 3'd4: begin
                    imm = 12'(rand_bits(12));
                    // shifts keep a legal funct7
                    if (f3 == 3'd1) begin
                        imm = {7'h00, imm[4:0]};
                    end else if (f3 == 3'd5) begin
                        imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                    end
                    prog.push_back(enc_i(imm, rand_bits(5), f3, rand_bits(5), 7'b0010011));
                end
                3'd5: prog.push_back(enc_u(20'(rand_bits(20)), rand_bits(5)));
                3'd6: begin
                    prog.push_back(enc_i(12'(rand_bits(7) << 2), 0, 3'd2, rand_bits(5),
                                         7'b0000011));
                end
                default: prog.push_back(enc_s(12'(rand_bits(7) << 2), rand_bits(5), 0));
            endcase
        end
        emit_dump();
    endtask

    initial begin
        build_alu_program();
        run_program("alu_forwarding");
        build_load_program();
        run_program("load_use");
        build_random_program(200);
        run_program("random");
        $display("All tests passed");
        $finish;
    end

endmodule

//--- sim.f
hw/pipe_sel.sv
hw/rv32i_types.sv
hw/regfile.sv
hw/decode_stage.sv
hw/forwarding_unit.sv
hw/hazard_detector.sv
hw/execute_stage.sv
hw/datapath.sv
tb/tb_datapath.sv

//--- Bender.yml
package:
  name: rv32i_pipe

sources:
  - hw/pipe_sel.sv
  - hw/rv32i_types.sv
  - hw/regfile.sv
  - hw/decode_stage.sv
  - hw/forwarding_unit.sv
  - hw/hazard_detector.sv
  - hw/execute_stage.sv
  - hw/datapath.sv
  - target: test
    files:
      - tb/tb_datapath.sv
